// ==== captcha_top.f ====
+incdir+src
src/captcha_pkg.sv
src/challenge_gen.sv
src/answer_judge.sv
src/scene_painter.sv
src/pixel_mixer.sv
src/captcha_top.sv
verif/captcha_tb.sv

// ==== src/answer_judge.sv ====
`timescale 1ns/1ps
`include "captcha_settings.svh"

module answer_judge (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                en,
    input  logic                btn_l,
    input  logic                btn_r,
    input  logic                btn_u,
    input  logic                btn_d,
    input  logic                btn_c,
    input  logic                challenge_valid,
    input  captcha_pkg::dir_t   challenge_dir,
    output captcha_pkg::dir_t   answer_dir,
    output captcha_pkg::focus_e focus,
    output logic                pass,
    output logic                fail
);
    import captcha_pkg::*;

    logic btn_l_q;
    logic btn_r_q;
    logic btn_u_q;
    logic btn_d_q;
    logic btn_c_q;
    logic l_rise;
    logic r_rise;
    logic u_rise;
    logic d_rise;
    logic c_rise;

    // last sample of each button
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            btn_l_q <= 1'b0;
            btn_r_q <= 1'b0;
            btn_u_q <= 1'b0;
            btn_d_q <= 1'b0;
            btn_c_q <= 1'b0;
        end else begin
            btn_l_q <= btn_l;
            btn_r_q <= btn_r;
            btn_u_q <= btn_u;
            btn_d_q <= btn_d;
            btn_c_q <= btn_c;
        end
    end

    assign l_rise = btn_l & ~btn_l_q;
    assign r_rise = btn_r & ~btn_r_q;
    assign u_rise = btn_u & ~btn_u_q;
    assign d_rise = btn_d & ~btn_d_q;
    assign c_rise = btn_c & ~btn_c_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            answer_dir <= 3'd0;
        end else if (en && focus == FOCUS_SLOTS) begin
            if (r_rise) begin
                answer_dir <= (answer_dir == `NUM_DIRS - 3'd1) ? 3'd0 : answer_dir + 3'd1;
            end else if (l_rise) begin
                answer_dir <= (answer_dir == 3'd0) ? `NUM_DIRS - 3'd1 : answer_dir - 3'd1;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            focus <= FOCUS_SLOTS;
        end else if (en) begin
            if (d_rise) begin
                focus <= FOCUS_SUBMIT;
            end else if (u_rise) begin
                focus <= FOCUS_SLOTS;
            end
        end
    end

    // verdict only counts from the submit box
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pass <= 1'b0;
            fail <= 1'b0;
        end else if (en && c_rise && focus == FOCUS_SUBMIT) begin
            if (challenge_valid && answer_dir == challenge_dir) begin
                pass <= 1'b1;
                fail <= 1'b0;
            end else begin
                pass <= 1'b0;
                fail <= 1'b1;
            end
        end
    end

endmodule

// ==== src/captcha_pkg.sv ====
package captcha_pkg;

    // screen column, 0..95
    typedef logic [6:0] x_coord_t;

    // screen row, 0..63
    typedef logic [5:0] y_coord_t;

    // rgb565 colour
    typedef logic [15:0] pixel_t;

    // answer or challenge direction, 0..5
    typedef logic [2:0] dir_t;

    // which part of the answer panel the buttons act on
    typedef enum logic {
        FOCUS_SLOTS  = 1'b0,
        FOCUS_SUBMIT = 1'b1
    } focus_e;

endpackage

// ==== src/captcha_settings.svh ====
`ifndef CAPTCHA_SETTINGS_SVH
`define CAPTCHA_SETTINGS_SVH

// oled panel size
`define SCREEN_W 96
`define SCREEN_H 64

// rgb565
`define COLOR_BLACK 16'h0000
`define COLOR_WHITE 16'hffff
`define COLOR_BLUE  16'h001f
`define COLOR_GREEN 16'h07e0
`define COLOR_GREY  16'ha514

`define NUM_DIRS 3'd6

// answer slots, 3x3 squares in a row
`define SLOT_X0    7'd39
`define SLOT_PITCH 7'd9
`define SLOT_WIDTH 7'd3
`define SLOT_Y_TOP 6'd40
`define SLOT_Y_BOT 6'd42

`define CURSOR_Y_TOP 6'd44
`define CURSOR_Y_BOT 6'd45

// dial disc
`define DIAL_CX 7'd43
`define DIAL_CY 6'd18
`define DIAL_R  7'd13

// marker centres, radius 8, clockwise from the top
`define MARK_X_0 7'd43
`define MARK_Y_0 6'd10
`define MARK_X_1 7'd50
`define MARK_Y_1 6'd14
`define MARK_X_2 7'd50
`define MARK_Y_2 6'd22
`define MARK_X_3 7'd43
`define MARK_Y_3 6'd26
`define MARK_X_4 7'd36
`define MARK_Y_4 6'd22
`define MARK_X_5 7'd36
`define MARK_Y_5 6'd14

// box outlines
`define DIGIT_X_L  7'd1
`define DIGIT_X_R  7'd24
`define DIGIT_Y_T  6'd1
`define DIGIT_Y_B  6'd34
`define TEXT_X_L   7'd27
`define TEXT_X_R   7'd94
`define TEXT_Y_T   6'd1
`define TEXT_Y_B   6'd34
`define SUBMIT_X_L 7'd28
`define SUBMIT_X_R 7'd64
`define SUBMIT_Y_T 6'd50
`define SUBMIT_Y_B 6'd58

`define LFSR_SEED 3'b101

`endif

// ==== src/captcha_top.sv ====
`timescale 1ns/1ps

module captcha_top (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  en,
    input  logic                  sw,
    input  logic                  btn_l,
    input  logic                  btn_r,
    input  logic                  btn_u,
    input  logic                  btn_d,
    input  logic                  btn_c,
    input  captcha_pkg::x_coord_t x,
    input  captcha_pkg::y_coord_t y,
    output captcha_pkg::pixel_t   oled_data,
    output logic                  pass,
    output logic                  fail
);
    import captcha_pkg::*;

    logic   challenge_valid;
    dir_t   challenge_dir;
    dir_t   answer_dir;
    focus_e focus;
    logic   scene_white;
    logic   scene_centre;

    challenge_gen challenge_gen_inst (
        .clock           (clock),
        .arst_n          (arst_n),
        .en              (en),
        .sw              (sw),
        .challenge_valid (challenge_valid),
        .challenge_dir   (challenge_dir)
    );

    answer_judge answer_judge_inst (
        .clock           (clock),
        .arst_n          (arst_n),
        .en              (en),
        .btn_l           (btn_l),
        .btn_r           (btn_r),
        .btn_u           (btn_u),
        .btn_d           (btn_d),
        .btn_c           (btn_c),
        .challenge_valid (challenge_valid),
        .challenge_dir   (challenge_dir),
        .answer_dir      (answer_dir),
        .focus           (focus),
        .pass            (pass),
        .fail            (fail)
    );

    // static shapes, no clock
    scene_painter scene_painter_inst (
        .x            (x),
        .y            (y),
        .scene_white  (scene_white),
        .scene_centre (scene_centre)
    );

    pixel_mixer pixel_mixer_inst (
        .clock           (clock),
        .arst_n          (arst_n),
        .en              (en),
        .x               (x),
        .y               (y),
        .scene_white     (scene_white),
        .scene_centre    (scene_centre),
        .answer_dir      (answer_dir),
        .focus           (focus),
        .challenge_valid (challenge_valid),
        .challenge_dir   (challenge_dir),
        .oled_data       (oled_data)
    );

endmodule

// ==== src/challenge_gen.sv ====
`timescale 1ns/1ps
`include "captcha_settings.svh"

module challenge_gen (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              en,
    input  logic              sw,
    output logic              challenge_valid,
    output captcha_pkg::dir_t challenge_dir
);
    import captcha_pkg::*;

    logic [2:0] lfsr;
    dir_t       lfsr_mod;

    // x^3 + x^2 + 1, walks all seven nonzero states
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            lfsr <= `LFSR_SEED;
        end else begin
            lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
        end
    end

    assign lfsr_mod = (lfsr >= `NUM_DIRS) ? lfsr - `NUM_DIRS : lfsr; // 6,7 fold to 0,1

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            challenge_valid <= 1'b0;
        end else if (!sw) begin
            challenge_valid <= 1'b0;
        end else if (en) begin
            challenge_valid <= 1'b1;
        end
    end

    // captured once per switch-on, held until release
    always_ff @(posedge clock) begin
        if (sw && en && !challenge_valid) begin
            challenge_dir <= lfsr_mod;
        end
    end

endmodule

// ==== src/pixel_mixer.sv ====
`timescale 1ns/1ps
`include "captcha_settings.svh"

module pixel_mixer (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  en,
    input  captcha_pkg::x_coord_t x,
    input  captcha_pkg::y_coord_t y,
    input  logic                  scene_white,
    input  logic                  scene_centre,
    input  captcha_pkg::dir_t     answer_dir,
    input  captcha_pkg::focus_e   focus,
    input  logic                  challenge_valid,
    input  captcha_pkg::dir_t     challenge_dir,
    output captcha_pkg::pixel_t   oled_data
);
    import captcha_pkg::*;

    x_coord_t cursor_l;
    x_coord_t mark_x;
    y_coord_t mark_y;
    logic     cursor_hit;
    logic     marker_hit;
    logic     submit_hit;
    pixel_t   colour;

    // bar sits under the chosen slot, same width
    assign cursor_l   = `SLOT_X0 + 7'(answer_dir) * `SLOT_PITCH;
    assign cursor_hit = x >= cursor_l && x < cursor_l + `SLOT_WIDTH &&
                        y >= `CURSOR_Y_TOP && y <= `CURSOR_Y_BOT;

    always_comb begin
        case (challenge_dir)
            3'd1:    begin mark_x = `MARK_X_1; mark_y = `MARK_Y_1; end
            3'd2:    begin mark_x = `MARK_X_2; mark_y = `MARK_Y_2; end
            3'd3:    begin mark_x = `MARK_X_3; mark_y = `MARK_Y_3; end
            3'd4:    begin mark_x = `MARK_X_4; mark_y = `MARK_Y_4; end
            3'd5:    begin mark_x = `MARK_X_5; mark_y = `MARK_Y_5; end
            default: begin mark_x = `MARK_X_0; mark_y = `MARK_Y_0; end
        endcase
    end

    // 3x3 around the marker point, offsets added on the pixel side
    assign marker_hit = challenge_valid &&
                        x + 7'd1 >= mark_x && x <= mark_x + 7'd1 &&
                        y + 6'd1 >= mark_y && y <= mark_y + 6'd1;

    assign submit_hit = (x >= `SUBMIT_X_L && x <= `SUBMIT_X_R &&
                         y >= `SUBMIT_Y_T && y <= `SUBMIT_Y_B) &&
                        (x == `SUBMIT_X_L || x == `SUBMIT_X_R ||
                         y == `SUBMIT_Y_T || y == `SUBMIT_Y_B);

    always_comb begin
        if (cursor_hit) begin
            colour = `COLOR_GREEN;
        end else if (marker_hit) begin
            colour = `COLOR_GREY;
        end else if (submit_hit) begin
            colour = (focus == FOCUS_SUBMIT) ? `COLOR_GREEN : `COLOR_WHITE;
        end else if (scene_centre) begin
            colour = `COLOR_BLUE;
        end else if (scene_white) begin
            colour = `COLOR_WHITE;
        end else begin
            colour = `COLOR_BLACK;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            oled_data <= `COLOR_BLACK;
        end else begin
            oled_data <= en ? colour : `COLOR_BLACK; // blank panel when disabled
        end
    end

endmodule

// ==== src/scene_painter.sv ====
`timescale 1ns/1ps
`include "captcha_settings.svh"

module scene_painter (
    input  captcha_pkg::x_coord_t x,
    input  captcha_pkg::y_coord_t y,
    output logic                  scene_white,
    output logic                  scene_centre
);
    import captcha_pkg::*;

    logic        digit_edge;
    logic        text_edge;
    logic        slot_hit;
    logic        disc_hit;
    x_coord_t    dx_abs;
    y_coord_t    dy_abs;
    logic [13:0] dist_sq;

    // one pixel wide rectangle outline
    function automatic logic box_edge(
        input x_coord_t px,
        input y_coord_t py,
        input x_coord_t l,
        input x_coord_t r,
        input y_coord_t t,
        input y_coord_t b
    );
        return (px >= l && px <= r && py >= t && py <= b) &&
               (px == l || px == r || py == t || py == b);
    endfunction

    assign digit_edge = box_edge(x, y, `DIGIT_X_L, `DIGIT_X_R, `DIGIT_Y_T, `DIGIT_Y_B);
    assign text_edge  = box_edge(x, y, `TEXT_X_L, `TEXT_X_R, `TEXT_Y_T, `TEXT_Y_B);

    always_comb begin
        slot_hit = 1'b0;
        for (int k = 0; k < `NUM_DIRS; k++) begin
            if (x >= `SLOT_X0 + 7'(k) * `SLOT_PITCH &&
                x <  `SLOT_X0 + 7'(k) * `SLOT_PITCH + `SLOT_WIDTH &&
                y >= `SLOT_Y_TOP && y <= `SLOT_Y_BOT) begin
                slot_hit = 1'b1;
            end
        end
    end

    // filled disc, distances kept unsigned
    assign dx_abs  = (x >= `DIAL_CX) ? x - `DIAL_CX : `DIAL_CX - x;
    assign dy_abs  = (y >= `DIAL_CY) ? y - `DIAL_CY : `DIAL_CY - y;
    assign dist_sq = 14'(dx_abs) * 14'(dx_abs) + 14'(dy_abs) * 14'(dy_abs); // at most 4729
    assign disc_hit = dist_sq <= 14'(`DIAL_R) * 14'(`DIAL_R);

    assign scene_white  = digit_edge | text_edge | slot_hit | disc_hit;
    assign scene_centre = (x == `DIAL_CX) && (y == `DIAL_CY);

endmodule

// ==== verif/captcha_tb.sv ====
`timescale 1ns/1ps
`include "captcha_settings.svh"

module captcha_tb;
    import captcha_pkg::*;

    localparam int BTN_L = 0;
    localparam int BTN_R = 1;
    localparam int BTN_U = 2;
    localparam int BTN_D = 3;
    localparam int BTN_C = 4;
    localparam int DIRS  = `NUM_DIRS;
    localparam int TRIES = 10; // scan attempts before a wait gives up

    logic     clock;
    logic     arst_n;
    logic     en;
    logic     sw;
    logic     btn_l;
    logic     btn_r;
    logic     btn_u;
    logic     btn_d;
    logic     btn_c;
    x_coord_t x;
    y_coord_t y;
    pixel_t   oled_data;
    logic     pass;
    logic     fail;

    int cursor_model; // expected slot under the bar
    int mark_idx;

    captcha_top captcha_top_inst (
        .clock     (clock),
        .arst_n    (arst_n),
        .en        (en),
        .sw        (sw),
        .btn_l     (btn_l),
        .btn_r     (btn_r),
        .btn_u     (btn_u),
        .btn_d     (btn_d),
        .btn_c     (btn_c),
        .x         (x),
        .y         (y),
        .oled_data (oled_data),
        .pass      (pass),
        .fail      (fail)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic drive_button(input int which, input logic level);
        case (which)
            BTN_L:   btn_l = level;
            BTN_R:   btn_r = level;
            BTN_U:   btn_u = level;
            BTN_D:   btn_d = level;
            default: btn_c = level;
        endcase
    endtask

    // one cycle high, one cycle low
    task automatic press(input int which);
        @(negedge clock);
        drive_button(which, 1'b1);
        @(negedge clock);
        drive_button(which, 1'b0);
    endtask

    task automatic read_pixel(input x_coord_t px, input y_coord_t py, output pixel_t val);
        @(negedge clock);
        x = px;
        y = py;
        @(negedge clock); // registered at the posedge in between
        val = oled_data;
    endtask

    task automatic check_pixel(input x_coord_t px, input y_coord_t py, input pixel_t exp,
                               input string what);
        pixel_t val;
        read_pixel(px, py, val);
        assert (val == exp) else stop_on_error($sformatf(
            "[FAIL] %0t: %s at (%0d,%0d) read %h, expected %h", $time, what, px, py, val, exp));
    endtask

    task automatic check_verdict(input logic exp_pass, input logic exp_fail, input string what);
        assert (pass === exp_pass && fail === exp_fail) else stop_on_error($sformatf(
            "[FAIL] %0t: %s, pass=%b fail=%b, expected pass=%b fail=%b",
            $time, what, pass, fail, exp_pass, exp_fail));
    endtask

    function automatic x_coord_t bar_x(input int k);
        return 7'(`SLOT_X0 + k * `SLOT_PITCH + 1); // middle column of the bar
    endfunction

    function automatic x_coord_t mark_x(input int k);
        case (k)
            0:       return `MARK_X_0;
            1:       return `MARK_X_1;
            2:       return `MARK_X_2;
            3:       return `MARK_X_3;
            4:       return `MARK_X_4;
            default: return `MARK_X_5;
        endcase
    endfunction

    function automatic y_coord_t mark_y(input int k);
        case (k)
            0:       return `MARK_Y_0;
            1:       return `MARK_Y_1;
            2:       return `MARK_Y_2;
            3:       return `MARK_Y_3;
            4:       return `MARK_Y_4;
            default: return `MARK_Y_5;
        endcase
    endfunction

    // bar under the expected slot only
    task automatic check_cursor(input int target);
        for (int k = 0; k < DIRS; k++) begin
            check_pixel(bar_x(k), `CURSOR_Y_TOP, (k == target) ? `COLOR_GREEN : `COLOR_BLACK,
                        $sformatf("cursor bar %0d", k));
        end
    endtask

    task automatic step_cursor(input bit right);
        if (right) begin
            press(BTN_R);
            cursor_model = (cursor_model + 1) % DIRS;
        end else begin
            press(BTN_L);
            cursor_model = (cursor_model + DIRS - 1) % DIRS;
        end
    endtask

    task automatic scan_markers(output int grey_cnt, output int idx, output int white_cnt);
        pixel_t val;
        grey_cnt = 0;
        white_cnt = 0;
        idx = 0;
        for (int k = 0; k < DIRS; k++) begin
            read_pixel(mark_x(k), mark_y(k), val);
            if (val == `COLOR_GREY) begin
                grey_cnt++;
                idx = k;
            end else if (val == `COLOR_WHITE) begin
                white_cnt++;
            end
        end
    endtask

    initial begin
        int  grey_cnt;
        int  idx;
        int  white_cnt;
        bit  found;
        bit  go_right;
        void'($urandom(79));
        arst_n = 1'b0;
        en = 1'b0;
        sw = 1'b0;
        btn_l = 1'b0;
        btn_r = 1'b0;
        btn_u = 1'b0;
        btn_d = 1'b0;
        btn_c = 1'b0;
        x = '0;
        y = '0;
        cursor_model = 0;
        mark_idx = 0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        check_verdict(1'b0, 1'b0, "verdict after reset");

        // panel dark and buttons dead while disabled
        check_pixel(`DIAL_CX, `DIAL_CY, `COLOR_BLACK, "dial centre while disabled");
        check_pixel(`DIGIT_X_L, 6'd10, `COLOR_BLACK, "digit box while disabled");
        check_pixel(bar_x(0), `CURSOR_Y_TOP, `COLOR_BLACK, "cursor bar while disabled");
        press(BTN_R);
        press(BTN_R);
        press(BTN_D);
        press(BTN_C);
        check_verdict(1'b0, 1'b0, "verdict after presses while disabled");

        @(negedge clock);
        en = 1'b1;
        check_pixel(`DIGIT_X_L, 6'd10, `COLOR_WHITE, "digit box outline");
        check_pixel(`DIAL_CX, `DIAL_CY, `COLOR_BLUE, "dial centre");
        check_pixel(7'(`SLOT_X0 + 2 * `SLOT_PITCH + 1), 6'd41, `COLOR_WHITE, "slot 2");
        check_pixel(7'd10, 6'd45, `COLOR_BLACK, "empty background");
        check_pixel(`SUBMIT_X_L, 6'd54, `COLOR_WHITE, "submit outline, slots focused");
        check_cursor(0);

        // both wraparounds first, then a random walk
        step_cursor(1'b0);
        check_cursor(cursor_model);
        step_cursor(1'b1);
        check_cursor(cursor_model);
        repeat (12) begin
            go_right = $urandom % 2;
            step_cursor(go_right);
            check_cursor(cursor_model);
        end

        @(negedge clock);
        sw = 1'b1;
        found = 1'b0;
        for (int tries = 0; tries < TRIES && !found; tries++) begin
            scan_markers(grey_cnt, idx, white_cnt);
            assert (grey_cnt <= 1) else stop_on_error($sformatf(
                "[FAIL] %0t: %0d dial markers grey at once", $time, grey_cnt));
            if (grey_cnt == 1) begin
                found = 1'b1;
                mark_idx = idx;
            end
        end
        if (!found) begin
            stop_on_error("timeout: no dial marker turned grey after the switch was raised");
        end
        repeat (3) begin
            scan_markers(grey_cnt, idx, white_cnt);
            assert (grey_cnt == 1 && idx == mark_idx) else stop_on_error($sformatf(
                "[FAIL] %0t: marker moved while switch held, %0d grey, at %0d not %0d",
                $time, grey_cnt, idx, mark_idx));
        end

        press(BTN_D);
        check_pixel(`SUBMIT_X_R, 6'd54, `COLOR_GREEN, "submit outline, submit focused");
        press(BTN_U);
        check_pixel(`SUBMIT_X_R, 6'd54, `COLOR_WHITE, "submit outline after up");

        for (int i = 0; i < DIRS && cursor_model != mark_idx; i++) begin
            step_cursor(1'b1);
        end
        check_cursor(mark_idx);
        press(BTN_D);
        press(BTN_C);
        check_verdict(1'b1, 1'b0, "matching answer");

        // cursor off the marker, so a counted press would give fail
        press(BTN_U);
        step_cursor(1'b1);
        press(BTN_C);
        check_verdict(1'b1, 1'b0, "centre press with slots focused");

        press(BTN_D);
        press(BTN_C);
        check_verdict(1'b0, 1'b1, "answer one slot off");

        // back to a pass so the release case shows a change
        press(BTN_U);
        step_cursor(1'b0);
        press(BTN_D);
        press(BTN_C);
        check_verdict(1'b1, 1'b0, "matching answer again");

        @(negedge clock);
        sw = 1'b0;
        found = 1'b0;
        for (int tries = 0; tries < TRIES && !found; tries++) begin
            scan_markers(grey_cnt, idx, white_cnt);
            if (white_cnt == DIRS) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            stop_on_error("timeout: dial markers did not return to the scene after release");
        end
        press(BTN_C);
        check_verdict(1'b0, 1'b1, "submit without a challenge");

        $display("Simulation PASSED");
        $finish;
    end

endmodule
